// File: pow_consts.svh
`ifndef POW_CONSTS_SVH
`define POW_CONSTS_SVH

// Datapath widths
`define W_OPERAND    8
`define W_RESULT     40

// RAM layout, operands low and results high
`define RAM_DEPTH    32
`define W_ADDR       5
`define OPERAND_BASE 0
`define RESULT_BASE  16
`define MAX_COUNT    16

// Seven-segment display timing
`define N_DIGITS     8
`define SCAN_CYCLES  16

// Pipeline latency, also the result buffer depth
`define PIPE_DEPTH   4

`endif

// File: bus_pkg.sv
`default_nettype none

`include "pow_consts.svh"

package bus_pkg;

    // Wishbone classic request from a master
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`W_ADDR-1:0]   adr;
        logic [`W_RESULT-1:0] dat;
    } wb_req_t;

    // Slave response back to the master
    typedef struct packed {
        logic                 ack;
        logic [`W_RESULT-1:0] dat;
    } wb_rsp_t;

    typedef logic [1:0] master_idx_t;

    localparam int          N_MASTERS = 3;
    localparam master_idx_t M_HOST    = 2'd0;
    localparam master_idx_t M_ENGINE  = 2'd1;
    localparam master_idx_t M_SCAN    = 2'd2;

endpackage

`default_nettype wire

// File: pow_pkg.sv
`default_nettype none

`include "pow_consts.svh"

package pow_pkg;

    // One slot of the multiply pipeline; idx is the operand number
    typedef struct packed {
        logic                          valid;
        logic [$clog2(`MAX_COUNT)-1:0] idx;
        logic [`W_OPERAND-1:0]         base;
        logic [`W_RESULT-1:0]          acc;
    } pow_stage_t;

    // Engine sequencing
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        DRAIN
    } engine_state_t;

endpackage

`default_nettype wire

// File: pow_pipeline.sv
`default_nettype none
`timescale 1ns/1ps

`include "pow_consts.svh"

module pow_pipeline
    import pow_pkg::*;
(
    input  wire        slow_clk,
    input  wire        rst,
    input  pow_stage_t in_stage,
    output pow_stage_t out_stage
);

    localparam int W_PAD = `W_RESULT - `W_OPERAND;

    pow_stage_t st [`PIPE_DEPTH];

    logic [`W_RESULT-1:0] in_base_ext;

    assign in_base_ext = {{W_PAD{1'b0}}, in_stage.base};

    // --------------------------------------------------
    // Stage 0 squares, later stages multiply by base
    // --------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_DEPTH; i++) begin
                st[i].valid <= 1'b0;
            end
        end else begin
            st[0].valid <= in_stage.valid;
            st[0].idx   <= in_stage.idx;
            st[0].base  <= in_stage.base;
            st[0].acc   <= in_base_ext * in_base_ext;

            for (int i = 1; i < `PIPE_DEPTH; i++) begin
                st[i].valid <= st[i-1].valid;
                st[i].idx   <= st[i-1].idx;
                st[i].base  <= st[i-1].base;
                // x^2 -> x^3 -> x^4 -> x^5, modulo 2^W_RESULT
                st[i].acc   <= st[i-1].acc * {{W_PAD{1'b0}}, st[i-1].base};
            end
        end
    end

    // Last stage holds base to the fifth power
    assign out_stage = st[`PIPE_DEPTH-1];

endmodule

`default_nettype wire

// File: pow_engine.sv
`default_nettype none
`timescale 1ns/1ps

`include "pow_consts.svh"

module pow_engine
    import bus_pkg::*;
    import pow_pkg::*;
(
    input  wire                          slow_clk,
    input  wire                          rst,
    input  wire                          start,
    input  wire [$clog2(`MAX_COUNT):0]   count,
    output logic                         busy,
    output logic                         done,
    output wb_req_t                      wb_req,
    input  wb_rsp_t                      wb_rsp
);

    localparam int W_IDX  = $clog2(`MAX_COUNT);
    localparam int W_CNT  = W_IDX + 1;
    localparam int W_PTR  = $clog2(`PIPE_DEPTH);
    localparam int W_CRED = $clog2(`PIPE_DEPTH + 1);
    localparam int W_A    = `W_ADDR;

    localparam logic [W_CRED-1:0]  FULL_CREDIT = W_CRED'(`PIPE_DEPTH);
    localparam logic [`W_ADDR-1:0] OP_BASE     = W_A'(`OPERAND_BASE);
    localparam logic [`W_ADDR-1:0] RES_BASE    = W_A'(`RESULT_BASE);

    engine_state_t state;

    logic [W_CNT-1:0]     n_ops;
    logic [W_CNT-1:0]     rd_idx;
    logic [W_CNT-1:0]     wr_done;
    logic [W_CRED-1:0]    credits;
    logic [W_IDX-1:0]     cur_idx;
    logic                 cyc;
    logic                 we;
    logic [`W_ADDR-1:0]   adr;
    logic [`W_RESULT-1:0] wdat;
    logic                 issue_rd;
    logic                 issue_wr;
    logic                 rd_ack;
    logic                 wr_ack;
    logic                 reads_left;

    pow_stage_t pipe_in;
    pow_stage_t pipe_out;
    pow_stage_t head;

    // Result buffer
    pow_stage_t       buf_mem [`PIPE_DEPTH];
    logic [W_PTR-1:0] buf_wp;
    logic [W_PTR-1:0] buf_rp;
    logic [W_CRED-1:0] buf_cnt;

    assign reads_left = (rd_idx != n_ops);
    assign rd_ack     = cyc && !we && wb_rsp.ack;
    assign wr_ack     = cyc && we && wb_rsp.ack;
    assign head       = buf_mem[buf_rp];

    // Writes win over reads whenever a result is waiting
    assign issue_wr = !cyc && (buf_cnt != '0)
                    && ((state == READ && reads_left) || state == DRAIN);
    assign issue_rd = !cyc && state == READ && reads_left
                    && (buf_cnt == '0) && (credits != '0);

    assign done = (state == DRAIN) && wr_ack && (wr_done == n_ops - W_CNT'(1));
    assign busy = (state != IDLE) && !done;

    // --------------------------------------------------
    // Sequencing and credits
    // --------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            cyc     <= 1'b0;
            we      <= 1'b0;
            n_ops   <= '0;
            rd_idx  <= '0;
            wr_done <= '0;
            credits <= '0;
        end else begin
            if (cyc && wb_rsp.ack) begin
                cyc <= 1'b0;
            end

            if (issue_rd) begin
                cyc     <= 1'b1;
                we      <= 1'b0;
                rd_idx  <= rd_idx + W_CNT'(1);
                credits <= credits - W_CRED'(1);
            end

            if (issue_wr) begin
                cyc <= 1'b1;
                we  <= 1'b1;
            end

            // Each stored result frees one slot
            if (wr_ack) begin
                wr_done <= wr_done + W_CNT'(1);
                credits <= credits + W_CRED'(1);
            end

            case (state)
                IDLE: begin
                    if (start) begin
                        n_ops   <= count;
                        rd_idx  <= '0;
                        wr_done <= '0;
                        credits <= FULL_CREDIT;
                        state   <= READ;
                    end
                end
                READ: begin
                    if (issue_wr) begin
                        state <= WRITE;
                    end else if (!cyc && !reads_left) begin
                        state <= DRAIN;
                    end
                end
                WRITE: begin
                    if (wr_ack) begin
                        state <= READ;
                    end
                end
                DRAIN: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data are held until ack
    always_ff @(posedge slow_clk) begin
        if (issue_rd) begin
            adr     <= OP_BASE + W_A'(rd_idx);
            cur_idx <= rd_idx[W_IDX-1:0];
        end
        if (issue_wr) begin
            adr  <= RES_BASE + W_A'(head.idx);
            wdat <= head.acc;
        end
    end

    assign wb_req = '{cyc: cyc, stb: cyc, we: we, adr: adr, dat: wdat};

    // --------------------------------------------------
    // Pipeline and result buffer
    // --------------------------------------------------

    assign pipe_in = '{
        valid: rd_ack,
        idx:   cur_idx,
        base:  wb_rsp.dat[`W_OPERAND-1:0],
        acc:   '0
    };

    pow_pipeline i_pow_pipeline (
        .slow_clk  (slow_clk),
        .rst       (rst),
        .in_stage  (pipe_in),
        .out_stage (pipe_out)
    );

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            buf_wp  <= '0;
            buf_rp  <= '0;
            buf_cnt <= '0;
        end else begin
            if (pipe_out.valid) begin
                buf_wp <= buf_wp + W_PTR'(1);
            end
            if (wr_ack) begin
                buf_rp <= buf_rp + W_PTR'(1);
            end
            case ({pipe_out.valid, wr_ack})
                2'b10:   buf_cnt <= buf_cnt + W_CRED'(1);
                2'b01:   buf_cnt <= buf_cnt - W_CRED'(1);
                default: buf_cnt <= buf_cnt;
            endcase
        end
    end

    always_ff @(posedge slow_clk) begin
        if (pipe_out.valid) begin
            buf_mem[buf_wp] <= pipe_out;
        end
    end

endmodule

`default_nettype wire

// File: seg_scanner.sv
`default_nettype none
`timescale 1ns/1ps

`include "pow_consts.svh"

module seg_scanner
    import bus_pkg::*;
(
    input  wire                     slow_clk,
    input  wire                     rst,
    input  wire [`W_ADDR-1:0]       sel,
    output wb_req_t                 wb_req,
    input  wb_rsp_t                 wb_rsp,
    output logic [7:0]              abcdefgh,
    output logic [`N_DIGITS-1:0]    digit
);

    localparam int SCAN_LEN  = `N_DIGITS * `SCAN_CYCLES;
    localparam int W_SCAN    = $clog2(SCAN_LEN);
    localparam int W_DIG_IDX = $clog2(`N_DIGITS);
    localparam int W_SHOWN   = 4 * `N_DIGITS;
    localparam int N_DIG     = `N_DIGITS;

    logic [W_SCAN-1:0]    scan_cnt;
    logic [W_DIG_IDX-1:0] dig_idx;
    logic                 cyc;
    logic [`W_ADDR-1:0]   adr;
    logic [W_SHOWN-1:0]   shown;
    logic [3:0]           nibble;

    // Active-high segments a..g, dot (h) always off
    function automatic logic [7:0] seg_code(input logic [3:0] hex);
        case (hex)
            4'h0: seg_code = 8'b1111_1100;
            4'h1: seg_code = 8'b0110_0000;
            4'h2: seg_code = 8'b1101_1010;
            4'h3: seg_code = 8'b1111_0010;
            4'h4: seg_code = 8'b0110_0110;
            4'h5: seg_code = 8'b1011_0110;
            4'h6: seg_code = 8'b1011_1110;
            4'h7: seg_code = 8'b1110_0000;
            4'h8: seg_code = 8'b1111_1110;
            4'h9: seg_code = 8'b1111_0110;
            4'ha: seg_code = 8'b1110_1110;
            4'hb: seg_code = 8'b0011_1110;
            4'hc: seg_code = 8'b1001_1100;
            4'hd: seg_code = 8'b0111_1010;
            4'he: seg_code = 8'b1001_1110;
            default: seg_code = 8'b1000_1110;
        endcase
    endfunction

    // Upper counter bits pick the digit
    assign dig_idx = scan_cnt[W_SCAN-1 -: W_DIG_IDX];
    assign nibble  = shown[4*dig_idx +: 4];

    // --------------------------------------------------
    // One read of sel per full scan
    // --------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            cyc      <= 1'b0;
        end else begin
            scan_cnt <= scan_cnt + W_SCAN'(1);
            if (cyc && wb_rsp.ack) begin
                cyc <= 1'b0;
            end else if (!cyc && scan_cnt == '0) begin
                cyc <= 1'b1;
            end
        end
    end

    always_ff @(posedge slow_clk) begin
        if (!cyc && scan_cnt == '0) begin
            adr <= sel;
        end
        if (cyc && wb_rsp.ack) begin
            shown <= wb_rsp.dat[W_SHOWN-1:0];
        end
    end

    assign wb_req = '{cyc: cyc, stb: cyc, we: 1'b0, adr: adr, dat: '0};

    // Digit 0 shows the least significant nibble
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            digit    <= '0;
            abcdefgh <= '0;
        end else begin
            digit    <= N_DIG'(1) << dig_idx;
            abcdefgh <= seg_code(nibble);
        end
    end

endmodule

`default_nettype wire

// File: wb_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module wb_arbiter
    import bus_pkg::*;
(
    input  wire      slow_clk,
    input  wire      rst,
    input  wb_req_t  m_req [N_MASTERS],
    output wb_rsp_t  m_rsp [N_MASTERS],
    output wb_req_t  s_req,
    input  wb_rsp_t  s_rsp
);

    master_idx_t owner;
    master_idx_t next_owner;
    logic        locked;
    logic        any_req;
    logic        release_bus;

    // Grant may move only when the owner has dropped cyc
    assign release_bus = !locked || !m_req[owner].cyc;

    // Nearest requester after the owner wins; owner itself is last
    always_comb begin
        next_owner = owner;
        any_req    = 1'b0;
        for (int k = N_MASTERS; k >= 1; k--) begin
            if (m_req[(int'(owner) + k) % N_MASTERS].cyc) begin
                next_owner = master_idx_t'((int'(owner) + k) % N_MASTERS);
                any_req    = 1'b1;
            end
        end
    end

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            owner  <= master_idx_t'(N_MASTERS - 1);
            locked <= 1'b0;
        end else if (release_bus) begin
            locked <= any_req;
            if (any_req) begin
                owner <= next_owner;
            end
        end
    end

    assign s_req = locked ? m_req[owner] : '0;

    // Waiting masters just see no ack
    always_comb begin
        for (int i = 0; i < N_MASTERS; i++) begin
            m_rsp[i].ack = locked && (owner == master_idx_t'(i)) && s_rsp.ack;
            m_rsp[i].dat = (owner == master_idx_t'(i)) ? s_rsp.dat : '0;
        end
    end

endmodule

`default_nettype wire

// File: wb_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "pow_consts.svh"

module wb_ram
    import bus_pkg::*;
(
    input  wire      slow_clk,
    input  wire      rst,
    input  wb_req_t  req,
    output wb_rsp_t  rsp
);

    logic [`W_RESULT-1:0] mem [`RAM_DEPTH];
    logic [`W_RESULT-1:0] rdata;
    logic                 ack;
    logic                 access;

    // A new access only when ack is low, so one ack per strobe
    assign access = req.cyc && req.stb && !ack;

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge slow_clk) begin
        if (access) begin
            if (req.we) begin
                mem[req.adr] <= req.dat;
            end
            rdata <= mem[req.adr];
        end
    end

    assign rsp = '{ack: ack, dat: rdata};

endmodule

`default_nettype wire

// File: pow_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "pow_consts.svh"

module pow_top
    import bus_pkg::*;
(
    input  wire                        slow_clk,
    input  wire                        rst,
    input  wire                        start,
    input  wire [$clog2(`MAX_COUNT):0] count,
    output logic                       busy,
    output logic                       done,
    input  wb_req_t                    host_req,
    output wb_rsp_t                    host_rsp,
    input  wire [`W_ADDR-1:0]          disp_sel,
    output logic [7:0]                 abcdefgh,
    output logic [`N_DIGITS-1:0]       digit
);

    wb_req_t m_req [N_MASTERS];
    wb_rsp_t m_rsp [N_MASTERS];
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;

    // Host port is master 0
    assign m_req[M_HOST] = host_req;
    assign host_rsp      = m_rsp[M_HOST];

    // --------------------------------------------------
    // Bus masters
    // --------------------------------------------------

    pow_engine i_pow_engine (
        .slow_clk (slow_clk),
        .rst      (rst),
        .start    (start),
        .count    (count),
        .busy     (busy),
        .done     (done),
        .wb_req   (m_req[M_ENGINE]),
        .wb_rsp   (m_rsp[M_ENGINE])
    );

    seg_scanner i_seg_scanner (
        .slow_clk (slow_clk),
        .rst      (rst),
        .sel      (disp_sel),
        .wb_req   (m_req[M_SCAN]),
        .wb_rsp   (m_rsp[M_SCAN]),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // --------------------------------------------------
    // Shared RAM behind the arbiter
    // --------------------------------------------------

    wb_arbiter i_wb_arbiter (
        .slow_clk (slow_clk),
        .rst      (rst),
        .m_req    (m_req),
        .m_rsp    (m_rsp),
        .s_req    (ram_req),
        .s_rsp    (ram_rsp)
    );

    wb_ram i_wb_ram (
        .slow_clk (slow_clk),
        .rst      (rst),
        .req      (ram_req),
        .rsp      (ram_rsp)
    );

endmodule

`default_nettype wire

// File: pow_assert.sv
`default_nettype none
`timescale 1ns/1ps

module pow_assert
    import bus_pkg::*;
    import pow_pkg::*;
(
    input wire           slow_clk,
    input wire           rst,
    input wb_req_t       req,
    input wb_rsp_t       rsp,
    input wire [2:0]     cyc_vec,
    input wire [2:0]     ack_vec,
    input engine_state_t state,
    input wire           done
);

    // At most one master sees ack in a cycle, and only one that is requesting
    ack_one_owner: assert property (
        @(posedge slow_clk) disable iff (rst)
        $onehot0(ack_vec) && ((ack_vec & ~cyc_vec) == 3'b000)
    ) else $error("more than one master acknowledged, or an idle master acknowledged");

    // Address held while the transfer waits
    adr_held: assert property (
        @(posedge slow_clk) disable iff (rst)
        req.cyc && req.stb && !rsp.ack |=> $stable(req.adr)
    ) else $error("bus address changed before the acknowledge");

    // done only closes a run that was already under way
    done_not_idle: assert property (
        @(posedge slow_clk) disable iff (rst) done |-> $past(state) != IDLE
    ) else $error("done raised while the engine is idle");

endmodule

// --------------------------------------------------
// Attach at the top level, seeing arbiter and engine
// --------------------------------------------------

bind pow_top pow_assert i_pow_assert (
    .slow_clk (slow_clk),
    .rst      (rst),
    .req      (ram_req),
    .rsp      (ram_rsp),
    .cyc_vec  ({m_req[2].cyc, m_req[1].cyc, m_req[0].cyc}),
    .ack_vec  ({m_rsp[2].ack, m_rsp[1].ack, m_rsp[0].ack}),
    .state    (i_pow_engine.state),
    .done     (done)
);

`default_nettype wire

// File: tb_pow_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "pow_consts.svh"

module tb_pow_top
    import bus_pkg::*;
();

    localparam int N_PAT     = 10;
    localparam int W_COUNT   = $clog2(`MAX_COUNT) + 1;
    localparam int SCAN_LEN  = `N_DIGITS * `SCAN_CYCLES;
    localparam int ACK_LIMIT = 100;
    localparam int RUN_LIMIT = 5000;

    localparam logic [`W_RESULT-1:0] POISON = 40'hEE_0000_0000;
    localparam logic [`W_RESULT-1:0] MARK   = 40'h5A_0000_0000;

    logic                 slow_clk;
    logic                 rst;
    logic                 start;
    logic [W_COUNT-1:0]   count;
    logic                 busy;
    logic                 done;
    wb_req_t              host_req;
    wb_rsp_t              host_rsp;
    logic [`W_ADDR-1:0]   disp_sel;
    logic [7:0]           abcdefgh;
    logic [`N_DIGITS-1:0] digit;

    logic [63:0]           pat_words [3*N_PAT];
    logic [`W_OPERAND-1:0] operands [`MAX_COUNT];
    logic [`W_RESULT-1:0]  expected [`MAX_COUNT];
    integer                seed;
    int                    error_count;
    int                    timeout_count;
    int                    busy_errors;
    int                    done_count;
    logic                  in_run;

    initial begin
        slow_clk = 1'b0;
        forever begin
            #5 slow_clk = ~slow_clk;
        end
    end

    pow_top i_pow_top (
        .slow_clk (slow_clk),
        .rst      (rst),
        .start    (start),
        .count    (count),
        .busy     (busy),
        .done     (done),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .disp_sel (disp_sel),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // --------------------------------------------------
    // Expected busy window and done pulse count
    // --------------------------------------------------

    always @(posedge slow_clk) begin
        if (rst) begin
            in_run      <= 1'b0;
            done_count  <= 0;
            busy_errors <= 0;
        end else begin
            assert (busy == (in_run && !done)) else begin
                busy_errors <= busy_errors + 1;
                $display("Error at %0t: busy is %0b outside the expected window", $time, busy);
            end
            assert (!done || in_run) else begin
                busy_errors <= busy_errors + 1;
                $display("Error at %0t: done pulse without a run", $time);
            end
            // start during a run is ignored
            if (done) begin
                done_count <= done_count + 1;
                in_run     <= 1'b0;
            end else if (start && !in_run) begin
                in_run <= 1'b1;
            end
        end
    end

    // x to the fifth, modulo 2^W_RESULT
    function automatic logic [`W_RESULT-1:0] fifth_power(input logic [`W_OPERAND-1:0] x);
        logic [`W_RESULT-1:0] p;
        p = 1;
        for (int i = 0; i < 5; i++) begin
            p = p * `W_RESULT'(x);
        end
        return p;
    endfunction

    task automatic bus_transfer(
        input  logic                 we,
        input  logic [`W_ADDR-1:0]   adr,
        input  logic [`W_RESULT-1:0] wdat,
        output logic [`W_RESULT-1:0] rdat
    );
        int n;
        n = 0;
        @(posedge slow_clk);
        host_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge slow_clk);
            n++;
        end while (!host_rsp.ack && n < ACK_LIMIT);
        rdat = host_rsp.dat;
        host_req <= '0;
        if (!host_rsp.ack) begin
            timeout_count++;
            $display("Timeout: host transfer at address %0d was never acknowledged", adr);
        end
    endtask

    task automatic load_batch(input int n);
        logic [`W_RESULT-1:0] val;
        for (int i = 0; i < n; i++) begin
            bus_transfer(1'b1, `W_ADDR'(`OPERAND_BASE + i), `W_RESULT'(operands[i]), val);
            bus_transfer(1'b1, `W_ADDR'(`RESULT_BASE + i), POISON + `W_RESULT'(i), val);
        end
    endtask

    task automatic start_run(input int n);
        @(posedge slow_clk);
        start <= 1'b1;
        count <= W_COUNT'(n);
        @(posedge slow_clk);
        start <= 1'b0;
    endtask

    task automatic wait_run_end(input int base);
        int n;
        n = 0;
        while (done_count == base && n < RUN_LIMIT) begin
            @(posedge slow_clk);
            n++;
        end
        if (done_count == base) begin
            timeout_count++;
            $display("Timeout: the engine never signalled done");
        end
    endtask

    task automatic check_results(input int n);
        logic [`W_RESULT-1:0] val;
        for (int i = 0; i < n; i++) begin
            bus_transfer(1'b0, `W_ADDR'(`RESULT_BASE + i), '0, val);
            assert (val == expected[i]) else begin
                error_count++;
                $display("Error at %0t: result %0d is %h, expected %h",
                         $time, i, val, expected[i]);
            end
            bus_transfer(1'b0, `W_ADDR'(`OPERAND_BASE + i), '0, val);
            assert (val == `W_RESULT'(operands[i])) else begin
                error_count++;
                $display("Error at %0t: operand %0d changed to %h", $time, i, val);
            end
        end
    endtask

    // Watch one full scan once the scanner has fetched the word
    task automatic check_display(input logic [`W_ADDR-1:0] sel, input logic [63:0] segs);
        logic [`N_DIGITS-1:0] seen;
        seen = '0;
        @(posedge slow_clk);
        disp_sel <= sel;
        repeat (3 * SCAN_LEN) @(posedge slow_clk);
        repeat (SCAN_LEN) begin
            @(posedge slow_clk);
            for (int i = 0; i < `N_DIGITS; i++) begin
                if (digit == (`N_DIGITS'(1) << i)) begin
                    seen[i] = 1'b1;
                    assert (abcdefgh == segs[8*i +: 8]) else begin
                        error_count++;
                        $display("Error at %0t: word %0d digit %0d shows %h, expected %h",
                                 $time, sel, i, abcdefgh, segs[8*i +: 8]);
                    end
                end
            end
        end
        assert (seen == '1) else begin
            error_count++;
            $display("Error at %0t: digits lit during one scan were %b", $time, seen);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        int                   base;
        int                   polls;
        logic [`W_ADDR-1:0]   adr;
        logic [`W_RESULT-1:0] val;

        seed          = 32'hf578_455b;
        error_count   = 0;
        timeout_count = 0;
        rst           = 1'b1;
        start         = 1'b0;
        count         = '0;
        host_req      = '0;
        disp_sel      = '0;
        $readmemh("pow_patterns.txt", pat_words);

        repeat (5) @(posedge slow_clk);
        assert (!busy && !done && !host_rsp.ack && digit == '0) else begin
            error_count++;
            $display("Error at %0t: outputs not idle in reset", $time);
        end
        rst <= 1'b0;

        // Pattern operands, plus a second start while busy
        for (int k = 0; k < N_PAT; k++) begin
            operands[k] = pat_words[3*k][`W_OPERAND-1:0];
            expected[k] = pat_words[3*k+1][`W_RESULT-1:0];
        end
        load_batch(N_PAT);
        base = done_count;
        start_run(N_PAT);
        repeat (4) @(posedge slow_clk);
        start <= 1'b1;
        count <= W_COUNT'(1);
        @(posedge slow_clk);
        start <= 1'b0;
        wait_run_end(base);
        repeat (SCAN_LEN) @(posedge slow_clk);
        assert (done_count == base + 1) else begin
            error_count++;
            $display("Error at %0t: %0d done pulses for one run", $time, done_count - base);
        end
        check_results(N_PAT);

        for (int k = 0; k < N_PAT; k++) begin
            check_display(`W_ADDR'(`RESULT_BASE + k), pat_words[3*k+2]);
        end

        // Full batch of random operands
        for (int k = 0; k < `MAX_COUNT; k++) begin
            operands[k] = `W_OPERAND'($random(seed));
            expected[k] = fifth_power(operands[k]);
        end
        load_batch(`MAX_COUNT);
        base = done_count;
        start_run(`MAX_COUNT);
        wait_run_end(base);
        check_results(`MAX_COUNT);

        // Host polls spare operand words while the engine and scanner run
        for (int k = 0; k < 8; k++) begin
            operands[k] = `W_OPERAND'($random(seed));
            expected[k] = fifth_power(operands[k]);
            bus_transfer(1'b1, `W_ADDR'(8 + k), MARK + `W_RESULT'(k), val);
        end
        load_batch(8);
        disp_sel <= `W_ADDR'(`RESULT_BASE + 2);
        base  = done_count;
        polls = 0;
        start_run(8);
        while (done_count == base && polls < RUN_LIMIT) begin
            adr = `W_ADDR'(8 + polls % 8);
            bus_transfer(1'b0, adr, '0, val);
            assert (val == MARK + `W_RESULT'(polls % 8)) else begin
                error_count++;
                $display("Error at %0t: poll of word %0d read %h", $time, adr, val);
            end
            polls++;
        end
        wait_run_end(base);
        check_results(8);

        repeat (10) @(posedge slow_clk);
        error_count = error_count + busy_errors;
        $display("Summary: %0d check errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pow_patterns.txt
// Columns: operand, operand to the fifth power (40 bits), display segment bytes
// The display column holds one a..h segment byte per digit, digit 7 first
00 0000000000 FCFCFCFCFCFCFCFC
01 0000000001 FCFCFCFCFCFCFC60
02 0000000020 FCFCFCFCFCFCDAFC
03 00000000F3 FCFCFCFCFCFC8EF2
05 0000000C35 FCFCFCFCFC9CF2B6
07 00000041A7 FCFCFCFC6660EEE0
10 0000100000 FCFC60FCFCFCFCFC
64 02540BE400 B666FC3E9E66FCFC
C8 4A817C8000 FE60E09CFEFCFCFC
FF FB09F604FF FCF68EBEFC668E8E

// File: sim.f
+incdir+.
bus_pkg.sv
pow_pkg.sv
pow_pipeline.sv
pow_engine.sv
seg_scanner.sv
wb_arbiter.sv
wb_ram.sv
pow_top.sv
pow_assert.sv
tb_pow_top.sv

// File: run_sim.sh
#!/bin/sh
# Build tb_pow_top with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pow_top -f sim.f -o sim_pow
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_pow)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
